// File: flist.f
+incdir+design
design/cpu_pkg.sv
design/reg_file.sv
design/decode.sv
design/execute.sv
design/cpu_core.sv
tb/cpu_core_assertions.sv
tb/cpu_core_tb.sv

// File: Makefile
# Verilator build and run for the cpu_core testbench

TOOL    := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := cpu_core_tb
FLIST   := flist.f
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the log decides the outcome
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/cpu_core_tb.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // expected outcome of one accepted instruction
    typedef struct packed {
        logic              has_result;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::word_t    data;
        cpu_pkg::flags_t   fl;
        logic [31:0]       accept;
    } exp_t;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    cpu_pkg::word_t    instr;
    logic              result_valid;
    cpu_pkg::reg_idx_t result_reg;
    cpu_pkg::word_t    result_data;
    cpu_pkg::flags_t   flags;

    // model state, in program order
    cpu_pkg::word_t  model_regs [`CPU_NREGS];
    cpu_pkg::flags_t model_fl;

    exp_t           exp_q [$];
    exp_t           head;
    cpu_pkg::word_t prog [$];
    logic [31:0]    cyc = '0;
    logic [31:0]    lcg_state = 32'h7631_6fc9;
    int             checks = 0;
    int             errors = 0;
    int             issued = 0;
    int             results = 0;
    int             test_base = 0;

    cpu_core uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result_reg   (result_reg),
        .result_data  (result_data),
        .flags        (flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // edge counter, sampled on the falling edge
    always @(posedge clk) cyc <= cyc + 32'd1;

    //////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic cpu_pkg::word_t rr_instr(input logic [4:0] op, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        cpu_pkg::word_t w;
        w = '0;
        w[`CPU_OP_MSB:`CPU_OP_LSB] = op;
        w[`CPU_RD_LSB +: `CPU_REG_BITS] = rd;
        w[`CPU_RS1_LSB +: `CPU_REG_BITS] = rs1;
        w[`CPU_RS2_LSB +: `CPU_REG_BITS] = rs2;
        return w;
    endfunction

    function automatic cpu_pkg::word_t imm_instr(input logic [4:0] op, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [16:0] imm);
        cpu_pkg::word_t w;
        w = rr_instr(op, rd, rs1, 5'd0);
        w[`CPU_IMM_BITS-1:0] = imm;
        return w;
    endfunction

    // reference model, one instruction, returns 1 when a result strobe is due
    function automatic logic ref_exec(input cpu_pkg::word_t ins,
                                      output cpu_pkg::reg_idx_t rd, output cpu_pkg::word_t res);
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t imm;
        logic [32:0]    wide;
        logic           defined;
        rd = ins[`CPU_RD_LSB +: `CPU_REG_BITS];
        a = model_regs[ins[`CPU_RS1_LSB +: `CPU_REG_BITS]];
        b = model_regs[ins[`CPU_RS2_LSB +: `CPU_REG_BITS]];
        imm = {{(32 - `CPU_IMM_BITS){ins[`CPU_IMM_BITS-1]}}, ins[`CPU_IMM_BITS-1:0]};
        wide = '0;
        defined = 1'b1;
        // bit 32 of wide is the carry, always 0 for logic, shift and lui
        case (ins[`CPU_OP_MSB:`CPU_OP_LSB])
            cpu_pkg::OP_ADD:  wide = {1'b0, a} + {1'b0, b};
            cpu_pkg::OP_SUB:  wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
            cpu_pkg::OP_ADC:  wide = {1'b0, a} + {1'b0, b} + {32'd0, model_fl.carry};
            cpu_pkg::OP_AND:  wide = {1'b0, a & b};
            cpu_pkg::OP_OR:   wide = {1'b0, a | b};
            cpu_pkg::OP_XOR:  wide = {1'b0, a ^ b};
            cpu_pkg::OP_SHL:  wide = {1'b0, a << b[4:0]};
            cpu_pkg::OP_SHR:  wide = {1'b0, a >> b[4:0]};
            cpu_pkg::OP_ADDI: wide = {1'b0, a} + {1'b0, imm};
            cpu_pkg::OP_LUI:  wide = {1'b0, imm << `CPU_LUI_SHIFT};
            default:          defined = 1'b0;
        endcase
        res = wide[31:0];
        if (defined) begin
            model_fl.zero = (res == '0);
            model_fl.carry = wide[32];
            if (rd != '0) begin
                model_regs[rd] = res;
            end
        end
        return defined && (rd != '0);
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s exp=%h got=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus tasks

    // drive one instruction on the falling edge, record what it should do
    task automatic issue(input cpu_pkg::word_t ins);
        exp_t              e;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::word_t    res;
        @(negedge clk);
        instr_valid = 1'b1;
        instr = ins;
        e.has_result = ref_exec(ins, rd, res);
        e.rd = rd;
        e.data = res;
        e.fl = model_fl;
        e.accept = cyc + 32'd1;
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    // bounded wait for all outstanding results
    task automatic drain_pipe();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 20) begin
            @(negedge clk);
            instr_valid = 1'b0;
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout at %0t: %0d expected results never arrived", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic run_prog(input int gap);
        foreach (prog[i]) begin
            issue(prog[i]);
            idle_cycles(gap);
        end
        drain_pipe();
        prog.delete();
    endtask

    task automatic report_test(input string name);
        $display("[%0t] test %s finished, %0d errors", $time, name, errors - test_base);
        test_base = errors;
    endtask

    //////////////////////////////////////////////////
    // comparison

    // head entry is due one edge after its acceptance edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (exp_q.size() > 0 && exp_q[0].accept + 32'd1 == cyc) begin
                head = exp_q.pop_front();
                check_word("result_valid", 32'(head.has_result), 32'(result_valid));
                if (head.has_result && result_valid) begin
                    check_word("result_reg", 32'(head.rd), 32'(result_reg));
                    check_word("result_data", head.data, result_data);
                    results++;
                end
                check_word("flags", 32'(head.fl), 32'(flags));
            end else begin
                assert (!result_valid) else begin
                    $display("unexpected result strobe at %0t for r%0d", $time, result_reg);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        model_fl = '0;
        foreach (model_regs[i]) model_regs[i] = '0;

        // 1. reset state
        repeat (3) begin
            @(negedge clk);
            check_word("result_valid", 32'd0, 32'(result_valid));
            check_word("flags", 32'd0, 32'(flags));
        end
        rst_n = 1'b1;
        idle_cycles(3);
        check_word("flags", 32'd0, 32'(flags));
        prog.push_back(rr_instr(cpu_pkg::OP_OR, 5'd1, 5'd5, 5'd0));
        run_prog(0);
        report_test("reset");

        // 2. each op alone, signed immediates
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd2, 5'd0, 17'd1234));
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd3, 5'd0, 17'h1fffb));
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd10, 5'd0, 17'd4));
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd4, 5'd2, 5'd3));
        prog.push_back(rr_instr(cpu_pkg::OP_SUB, 5'd5, 5'd2, 5'd3));
        prog.push_back(rr_instr(cpu_pkg::OP_AND, 5'd6, 5'd2, 5'd3));
        prog.push_back(rr_instr(cpu_pkg::OP_OR, 5'd7, 5'd2, 5'd3));
        prog.push_back(rr_instr(cpu_pkg::OP_XOR, 5'd8, 5'd2, 5'd3));
        prog.push_back(rr_instr(cpu_pkg::OP_SHL, 5'd9, 5'd2, 5'd10));
        prog.push_back(rr_instr(cpu_pkg::OP_SHR, 5'd11, 5'd3, 5'd10));
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd12, 5'd2, 17'h10000));
        prog.push_back(imm_instr(cpu_pkg::OP_LUI, 5'd13, 5'd0, 17'h0abcd));
        prog.push_back(imm_instr(cpu_pkg::OP_LUI, 5'd14, 5'd0, 17'h1abcd));
        run_prog(2);
        report_test("single ops");

        // 3. back-to-back dependencies, distance one to three
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 17'd7));
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd2, 5'd0, 17'd3));
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd3, 5'd1, 5'd2));
        prog.push_back(rr_instr(cpu_pkg::OP_SUB, 5'd4, 5'd3, 5'd1));
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd5, 5'd4, 5'd4));
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd6, 5'd1, 5'd3));
        prog.push_back(rr_instr(cpu_pkg::OP_XOR, 5'd7, 5'd5, 5'd4));
        prog.push_back(rr_instr(cpu_pkg::OP_OR, 5'd8, 5'd7, 5'd7));
        run_prog(0);
        report_test("dependencies");

        // 4. carry chain with adc and borrow
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 17'h1ffff));
        prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd2, 5'd0, 17'd1));
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd3, 5'd1, 5'd2));
        prog.push_back(rr_instr(cpu_pkg::OP_ADC, 5'd4, 5'd2, 5'd2));
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd5, 5'd1, 5'd1));
        prog.push_back(rr_instr(cpu_pkg::OP_ADC, 5'd6, 5'd0, 5'd0));
        prog.push_back(rr_instr(cpu_pkg::OP_SUB, 5'd7, 5'd2, 5'd1));
        prog.push_back(rr_instr(cpu_pkg::OP_SUB, 5'd8, 5'd1, 5'd2));
        prog.push_back(rr_instr(cpu_pkg::OP_SUB, 5'd9, 5'd2, 5'd2));
        prog.push_back(rr_instr(cpu_pkg::OP_ADC, 5'd10, 5'd0, 5'd0));
        run_prog(0);
        report_test("carry chain");

        // 5. r0 writes and undefined opcodes, flags still tracked
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd0, 5'd1, 5'd1));
        prog.push_back(rr_instr(cpu_pkg::OP_OR, 5'd14, 5'd0, 5'd0));
        prog.push_back(rr_instr(cpu_pkg::OP_ADD, 5'd0, 5'd1, 5'd1));
        prog.push_back(rr_instr(5'h0c, 5'd3, 5'd1, 5'd1));
        prog.push_back(rr_instr(5'h1f, 5'd4, 5'd1, 5'd2));
        prog.push_back(rr_instr(cpu_pkg::OP_ADC, 5'd12, 5'd0, 5'd0));
        prog.push_back(rr_instr(cpu_pkg::OP_OR, 5'd11, 5'd0, 5'd0));
        run_prog(1);
        report_test("no result");

        // 6. random stream, small register window for more hazards
        for (int k = 0; k < 200; k++) begin
            logic [31:0]    r;
            cpu_pkg::word_t ins;
            r = next_rand();
            ins = next_rand();
            if (r[3:0] < 4'd12) begin
                ins[`CPU_OP_MSB:`CPU_OP_LSB] = 5'(r[31:16] % 16'd10);
            end else begin
                ins[`CPU_OP_MSB:`CPU_OP_LSB] = {1'b1, r[7:4]};
            end
            ins[`CPU_RD_LSB + 3 +: 2] = 2'b00;
            ins[`CPU_RS1_LSB + 3 +: 2] = 2'b00;
            if (ins[`CPU_OP_MSB:`CPU_OP_LSB] < 5'd8) begin
                ins[`CPU_RS2_LSB + 3 +: 2] = 2'b00;
            end
            issue(ins);
            if (r[9:8] == 2'b00) begin
                idle_cycles(1 + int'(r[10]));
            end
        end
        drain_pipe();
        report_test("random stream");

        $display("checks %0d, errors %0d, instructions %0d, results %0d",
                 checks, errors, issued, results);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/cpu_core_assertions.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_core_assertions (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  cpu_pkg::word_t    instr,
    input  logic              result_valid,
    input  cpu_pkg::reg_idx_t result_reg,
    input  cpu_pkg::word_t    result_data,
    input  cpu_pkg::flags_t   flags
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////
    // result strobe timing

    // strobe two edges after an accepted write to the same nonzero index
    a_result_from_accept: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(instr_valid, 2) && (result_reg != '0)
            && ($past(instr[`CPU_RD_LSB +: `CPU_REG_BITS], 2) == result_reg))
        else $error("result strobe without a matching accepted write");

    // no unknown bits on the result bus
    a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> !$isunknown(result_data))
        else $error("result_data has unknown bits while result_valid is high");

    //////////////////////////////////////////////////
    // FL timing

    // FL moves only as the execute/writeback register loads
    a_flags_timing: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(flags) |-> $past(instr_valid, 2))
        else $error("flags changed without an instruction accepted two edges earlier");

endmodule

bind cpu_core cpu_core_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result_reg   (result_reg),
    .result_data  (result_data),
    .flags        (flags)
);

`default_nettype wire

// File: design/cpu_core.sv
`default_nettype none

module cpu_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  cpu_pkg::word_t    instr,
    output logic              result_valid,
    output cpu_pkg::reg_idx_t result_reg,
    output cpu_pkg::word_t    result_data,
    output cpu_pkg::flags_t   flags
);

    // register read, decode to reg_file and back
    cpu_pkg::reg_idx_t rd_addr_a;
    cpu_pkg::reg_idx_t rd_addr_b;
    cpu_pkg::word_t    rd_data_a;
    cpu_pkg::word_t    rd_data_b;

    // decode/execute register
    logic              de_valid;
    cpu_pkg::alu_op_t  de_op;
    cpu_pkg::alu_src_t de_src;
    cpu_pkg::reg_idx_t de_rs1;
    cpu_pkg::reg_idx_t de_rs2;
    cpu_pkg::reg_idx_t de_rd;
    logic              de_wr_en;
    cpu_pkg::word_t    de_a;
    cpu_pkg::word_t    de_b;
    cpu_pkg::word_t    de_imm;

    //////////////////////////////////////////////////
    // decode stage
    decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .de_valid    (de_valid),
        .de_op       (de_op),
        .de_src      (de_src),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_rd       (de_rd),
        .de_wr_en    (de_wr_en),
        .de_a        (de_a),
        .de_b        (de_b),
        .de_imm      (de_imm)
    );

    //////////////////////////////////////////////////
    // register file, written by the result bus
    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (result_valid),
        .wr_addr   (result_reg),
        .wr_data   (result_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    //////////////////////////////////////////////////
    // execute stage, wb register drives the result ports
    execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .de_valid (de_valid),
        .de_op    (de_op),
        .de_src   (de_src),
        .de_rs1   (de_rs1),
        .de_rs2   (de_rs2),
        .de_rd    (de_rd),
        .de_wr_en (de_wr_en),
        .de_a     (de_a),
        .de_b     (de_b),
        .de_imm   (de_imm),
        .wb_valid (result_valid),
        .wb_rd    (result_reg),
        .wb_data  (result_data),
        .flags    (flags)
    );

endmodule

`default_nettype wire

// File: design/execute.sv
`default_nettype none

`include "cpu_defines.svh"

module execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              de_valid,
    input  cpu_pkg::alu_op_t  de_op,
    input  cpu_pkg::alu_src_t de_src,
    input  cpu_pkg::reg_idx_t de_rs1,
    input  cpu_pkg::reg_idx_t de_rs2,
    input  cpu_pkg::reg_idx_t de_rd,
    input  logic              de_wr_en,
    input  cpu_pkg::word_t    de_a,
    input  cpu_pkg::word_t    de_b,
    input  cpu_pkg::word_t    de_imm,
    output logic              wb_valid,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_data,
    output cpu_pkg::flags_t   flags
);

    // shift amount taken from low bits of operand b
    localparam int SHAMT_BITS = $clog2(`CPU_XLEN);

    //////////////////////////////////////////////////
    // forwarding

    logic           fwd_a;
    logic           fwd_b;
    cpu_pkg::word_t op_a;
    cpu_pkg::word_t reg_b;
    cpu_pkg::word_t op_b;

    // wb register holds the previous instruction's write
    // wb_valid already excludes r0
    assign fwd_a = wb_valid && (wb_rd == de_rs1);
    assign fwd_b = wb_valid && (wb_rd == de_rs2);

    assign op_a  = fwd_a ? wb_data : de_a;
    assign reg_b = fwd_b ? wb_data : de_b;

    // immediate ops ignore rs2
    assign op_b  = (de_src == cpu_pkg::SRC_IMM) ? de_imm : reg_b;

    //////////////////////////////////////////////////
    // ALU

    // one shared 33-bit adder for add, adc, addi, sub
    cpu_pkg::word_t      add_b;
    logic                add_cin;
    logic [`CPU_XLEN:0]  add_sum;

    always_comb begin
        add_b   = op_b;
        add_cin = 1'b0;
        case (de_op)
            // rs1 + ~rs2 + 1
            cpu_pkg::OP_SUB: begin
                add_b   = ~op_b;
                add_cin = 1'b1;
            end
            // carry in from FL
            cpu_pkg::OP_ADC: begin
                add_cin = flags.carry;
            end
            default: begin
            end
        endcase
    end

    assign add_sum = {1'b0, op_a} + {1'b0, add_b} + {{`CPU_XLEN{1'b0}}, add_cin};

    cpu_pkg::word_t alu_res;
    logic           alu_carry;

    always_comb begin
        alu_res   = '0;
        alu_carry = 1'b0;
        case (de_op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
            cpu_pkg::OP_ADC, cpu_pkg::OP_ADDI: begin
                alu_res   = add_sum[`CPU_XLEN-1:0];
                alu_carry = add_sum[`CPU_XLEN];
            end
            // logic ops, carry cleared
            cpu_pkg::OP_AND: alu_res = op_a & op_b;
            cpu_pkg::OP_OR:  alu_res = op_a | op_b;
            cpu_pkg::OP_XOR: alu_res = op_a ^ op_b;
            // logical shifts
            cpu_pkg::OP_SHL: alu_res = op_a << op_b[SHAMT_BITS-1:0];
            cpu_pkg::OP_SHR: alu_res = op_a >> op_b[SHAMT_BITS-1:0];
            // upper immediate
            cpu_pkg::OP_LUI: alu_res = de_imm << `CPU_LUI_SHIFT;
            // undefined op, nothing
            default: begin
            end
        endcase
    end

    //////////////////////////////////////////////////
    // flags

    cpu_pkg::flags_t fl_next;
    logic            fl_update;

    assign fl_next.zero  = (alu_res == '0);
    assign fl_next.carry = alu_carry;

    // every defined op updates FL, even with rd = r0
    assign fl_update = de_valid && (de_op != cpu_pkg::OP_NOP);

    //////////////////////////////////////////////////
    // execute/writeback register

    // control and FL
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            flags    <= '0;
        end else begin
            wb_valid <= de_valid & de_wr_en;
            if (fl_update) begin
                flags <= fl_next;
            end
        end
    end

    // result payload
    // also the writeback bus to reg_file
    always_ff @(posedge clk) begin
        if (de_valid && de_wr_en) begin
            wb_rd   <= de_rd;
            wb_data <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: design/decode.sv
`default_nettype none

`include "cpu_defines.svh"

module decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::word_t    rd_data_a,
    input  cpu_pkg::word_t    rd_data_b,
    output cpu_pkg::reg_idx_t rd_addr_a,
    output cpu_pkg::reg_idx_t rd_addr_b,
    output logic              de_valid,
    output cpu_pkg::alu_op_t  de_op,
    output cpu_pkg::alu_src_t de_src,
    output cpu_pkg::reg_idx_t de_rs1,
    output cpu_pkg::reg_idx_t de_rs2,
    output cpu_pkg::reg_idx_t de_rd,
    output logic              de_wr_en,
    output cpu_pkg::word_t    de_a,
    output cpu_pkg::word_t    de_b,
    output cpu_pkg::word_t    de_imm
);

    //////////////////////////////////////////////////
    // field split

    logic [4:0]        op_field;
    cpu_pkg::reg_idx_t rd_field;
    cpu_pkg::reg_idx_t rs1_field;
    cpu_pkg::reg_idx_t rs2_field;
    cpu_pkg::word_t    imm_ext;

    assign op_field  = instr[`CPU_OP_MSB:`CPU_OP_LSB];
    assign rd_field  = instr[`CPU_RD_LSB +: `CPU_REG_BITS];
    assign rs1_field = instr[`CPU_RS1_LSB +: `CPU_REG_BITS];
    assign rs2_field = instr[`CPU_RS2_LSB +: `CPU_REG_BITS];

    // sign-extend low immediate bits to a full word
    assign imm_ext = {{(`CPU_XLEN - `CPU_IMM_BITS){instr[`CPU_IMM_BITS-1]}},
                      instr[`CPU_IMM_BITS-1:0]};

    // register reads, answered in this same cycle
    // rs2 overlaps the immediate, harmless for imm ops
    assign rd_addr_a = rs1_field;
    assign rd_addr_b = rs2_field;

    //////////////////////////////////////////////////
    // opcode classify

    cpu_pkg::alu_op_t  op_dec;
    cpu_pkg::alu_src_t src_dec;
    logic              op_defined;

    always_comb begin
        op_dec     = cpu_pkg::OP_NOP;
        src_dec    = cpu_pkg::SRC_REG;
        op_defined = 1'b0;
        case (op_field)
            // register-register ops
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_ADC,
            cpu_pkg::OP_AND, cpu_pkg::OP_OR,  cpu_pkg::OP_XOR,
            cpu_pkg::OP_SHL, cpu_pkg::OP_SHR: begin
                op_dec     = cpu_pkg::alu_op_t'(op_field);
                op_defined = 1'b1;
            end
            // immediate ops
            cpu_pkg::OP_ADDI, cpu_pkg::OP_LUI: begin
                op_dec     = cpu_pkg::alu_op_t'(op_field);
                src_dec    = cpu_pkg::SRC_IMM;
                op_defined = 1'b1;
            end
            // undefined, stays a no-op
            default: begin
            end
        endcase
    end

    //////////////////////////////////////////////////
    // decode/execute register

    // control half
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
            de_wr_en <= 1'b0;
        end else begin
            de_valid <= instr_valid;
            // the only place r0 is compared
            de_wr_en <= instr_valid & op_defined & (rd_field != '0);
        end
    end

    // payload half, loaded per accepted instruction
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            de_op  <= op_dec;
            de_src <= src_dec;
            de_rs1 <= rs1_field;
            de_rs2 <= rs2_field;
            de_rd  <= rd_field;
            de_a   <= rd_data_a;
            de_b   <= rd_data_b;
            de_imm <= imm_ext;
        end
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

`include "cpu_defines.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rd_addr_a,
    input  cpu_pkg::reg_idx_t rd_addr_b,
    input  logic              wr_en,
    input  cpu_pkg::reg_idx_t wr_addr,
    input  cpu_pkg::word_t    wr_data,
    output cpu_pkg::word_t    rd_data_a,
    output cpu_pkg::word_t    rd_data_b
);

    // register array
    cpu_pkg::word_t regs [`CPU_NREGS];

    //////////////////////////////////////////////////
    // write port

    // r0 is never written since decode drops writes to it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // read ports with write-through

    // a read hitting the writeback index sees the new value
    always_comb begin
        if (wr_en && (wr_addr == rd_addr_a)) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (wr_en && (wr_addr == rd_addr_b)) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // one data word
    typedef logic [`CPU_XLEN-1:0] word_t;

    // register index
    typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;

    // opcode encodings
    // anything not listed here is undefined and decodes to OP_NOP
    typedef enum logic [4:0] {
        OP_ADD  = 5'h00,
        OP_SUB  = 5'h01,
        OP_ADC  = 5'h02,
        OP_AND  = 5'h03,
        OP_OR   = 5'h04,
        OP_XOR  = 5'h05,
        OP_SHL  = 5'h06,
        OP_SHR  = 5'h07,
        OP_ADDI = 5'h08,
        OP_LUI  = 5'h09,
        OP_NOP  = 5'h1f
    } alu_op_t;

    // FL register, zero above carry
    typedef struct packed {
        logic zero;
        logic carry;
    } flags_t;

    // second ALU operand source
    typedef enum logic {
        SRC_REG = 1'b0,
        SRC_IMM = 1'b1
    } alu_src_t;

endpackage

`default_nettype wire

// File: design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath word and register file size
`define CPU_XLEN      32
`define CPU_NREGS     32
`define CPU_REG_BITS  5

// opcode field, bits 31..27
`define CPU_OP_MSB    31
`define CPU_OP_LSB    27

// register fields, low bit of each 5-bit field
`define CPU_RD_LSB    22
`define CPU_RS1_LSB   17
`define CPU_RS2_LSB   12

// immediate in bits 16..0, sign-extended
`define CPU_IMM_BITS  17

// lui places the immediate above this bit
`define CPU_LUI_SHIFT 15

`endif
